//--- filelist.f
source/cpu_pkg.sv
source/fetch_unit.sv
source/prefetch_queue.sv
source/execute_unit.sv
source/bus_master.sv
source/cpu_top.sv
testbench/tb_memory.sv
testbench/tb_cpu_top.sv

//--- testbench/tb_cpu_top.sv
// Testbench for the CPU core
// Runs a fixed program through a reference model, then compares the
// stores, the fetch order and the sync count; bus rules checked live
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	// Worst case fetch takes six cycles, stores add more
	localparam int CYCLES_PER_BYTE = 8;
	localparam logic [15:0] RESET_VECTOR = 16'h0200;
	localparam logic [15:0] HALT_ADDR = 16'hFFF0;
	localparam logic [15:0] SKIP_ADDR = 16'h0320;
	localparam logic [31:0] SEED = 32'h8a835e6c;

	logic        phi2_int;
	logic        rst_n;
	wire  [7:0]  wb_dat_r;
	wire         wb_ack;
	wire         wb_cyc;
	wire         wb_stb;
	wire         wb_we;
	wire  [15:0] wb_adr;
	wire  [7:0]  wb_dat_w;
	wire         sync;

	logic [7:0]  prog [$];
	logic [23:0] exp_stores [$];
	logic [15:0] jump_targets [$];
	logic [16:0] xfer_log [$];
	int          prog_len = 0;
	int          model_instr = 0;
	int          sync_count = 0;
	logic        stb_seen = 1'b0;

	cpu_top #(
		.QUEUE_DEPTH  (4),
		.RESET_VECTOR (RESET_VECTOR)
	) i_dut (
		.phi2_int (phi2_int),
		.rst_n    (rst_n),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.sync     (sync)
	);

	tb_memory #(
		.SEED      (SEED),
		.HALT_ADDR (HALT_ADDR)
	) i_mem (
		.phi2_int (phi2_int),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	////////////////////
	// Program building

	task automatic put_op(input logic [7:0] op);
		prog.push_back(op);
	endtask

	task automatic put_imm(input logic [7:0] op, input logic [7:0] value);
		prog.push_back(op);
		prog.push_back(value);
	endtask

	task automatic put_abs(input logic [7:0] op, input logic [15:0] addr);
		prog.push_back(op);
		prog.push_back(addr[7:0]);
		prog.push_back(addr[15:8]);
	endtask

	task automatic build_program();
		int          jmp_at;
		logic [15:0] target;
		// ALU ops, each result stored
		put_imm(cpu_pkg::OP_LDA_IMM, 8'h3C);
		put_abs(cpu_pkg::OP_STA_ABS, 16'h0300);
		put_op(cpu_pkg::OP_CLC);
		put_imm(cpu_pkg::OP_ADC_IMM, 8'h25);
		put_abs(cpu_pkg::OP_STA_ABS, 16'h0301);
		put_op(cpu_pkg::OP_SEC);
		put_imm(cpu_pkg::OP_ADC_IMM, 8'hF0);
		put_abs(cpu_pkg::OP_STA_ABS, 16'h0302);
		put_imm(cpu_pkg::OP_ADC_IMM, 8'h10);
		put_abs(cpu_pkg::OP_STA_ABS, 16'h0303);
		put_imm(cpu_pkg::OP_AND_IMM, 8'h0F);
		put_abs(cpu_pkg::OP_STA_ABS, 16'h0304);
		put_imm(cpu_pkg::OP_ORA_IMM, 8'hA0);
		put_abs(cpu_pkg::OP_STA_ABS, 16'h0305);
		put_imm(cpu_pkg::OP_EOR_IMM, 8'hFF);
		put_abs(cpu_pkg::OP_STA_ABS, 16'h0306);
		// Transfers, increments with wrap, carry clear
		put_op(cpu_pkg::OP_TAX);
		put_op(cpu_pkg::OP_TAY);
		put_op(cpu_pkg::OP_INY);
		put_imm(cpu_pkg::OP_LDX_IMM, 8'hFE);
		put_op(cpu_pkg::OP_INX);
		put_op(cpu_pkg::OP_INX);
		put_abs(cpu_pkg::OP_STX_ABS, 16'h0310);
		put_imm(cpu_pkg::OP_LDY_IMM, 8'hFF);
		put_op(cpu_pkg::OP_INY);
		put_op(cpu_pkg::OP_SEC);
		put_op(cpu_pkg::OP_CLC);
		put_imm(cpu_pkg::OP_LDA_IMM, 8'h80);
		put_imm(cpu_pkg::OP_ADC_IMM, 8'h80);
		put_abs(cpu_pkg::OP_STA_ABS, 16'h0311);
		put_imm(cpu_pkg::OP_ADC_IMM, 8'h00);
		put_abs(cpu_pkg::OP_STA_ABS, 16'h0312);
		put_op(cpu_pkg::OP_TAX);
		put_op(cpu_pkg::OP_INX);
		put_abs(cpu_pkg::OP_STX_ABS, 16'h0313);
		// Opcodes outside the kept set run as one byte NOPs
		put_op(8'h02);
		put_op(8'hFF);
		put_op(8'h91);
		put_op(cpu_pkg::OP_NOP);
		put_abs(cpu_pkg::OP_STA_ABS, 16'h0314);
		// Jump over a block longer than the prefetch reach
		jmp_at = prog.size();
		put_abs(cpu_pkg::OP_JMP_ABS, 16'h0000);
		put_abs(cpu_pkg::OP_STA_ABS, SKIP_ADDR);
		put_imm(cpu_pkg::OP_LDA_IMM, 8'h77);
		put_op(cpu_pkg::OP_NOP);
		put_op(cpu_pkg::OP_NOP);
		put_op(cpu_pkg::OP_NOP);
		target = RESET_VECTOR + 16'(prog.size());
		prog[jmp_at + 1] = target[7:0];
		prog[jmp_at + 2] = target[15:8];
		put_abs(cpu_pkg::OP_STA_ABS, 16'h0321);
		put_imm(cpu_pkg::OP_LDA_IMM, 8'h99);
		put_abs(cpu_pkg::OP_STA_ABS, 16'h0322);
		put_abs(cpu_pkg::OP_STX_ABS, 16'h0323);
		put_abs(cpu_pkg::OP_JMP_ABS, HALT_ADDR);
	endtask

	////////////////////
	// Reference model

	// Bytes outside the program read as NOP
	function automatic logic [7:0] prog_byte(input logic [15:0] addr);
		int idx;
		idx = int'(addr) - int'(RESET_VECTOR);
		if (idx >= 0 && idx < prog.size()) begin
			return prog[idx];
		end
		return 8'hEA;
	endfunction

	task automatic run_model();
		logic [15:0] pc;
		logic [15:0] target;
		logic [7:0]  op;
		logic [7:0]  lo;
		logic [7:0]  a;
		logic [7:0]  x;
		logic [7:0]  y;
		logic [8:0]  sum;
		logic        c;
		logic        halted;
		int          steps;
		pc     = RESET_VECTOR;
		a      = '0;
		x      = '0;
		y      = '0;
		c      = 1'b0;
		halted = 1'b0;
		steps  = 0;
		while (!halted && steps < 1000) begin
			op     = prog_byte(pc);
			lo     = prog_byte(pc + 16'd1);
			target = {prog_byte(pc + 16'd2), lo};
			model_instr++;
			steps++;
			case (op)
				cpu_pkg::OP_LDA_IMM: a = lo;
				cpu_pkg::OP_LDX_IMM: x = lo;
				cpu_pkg::OP_LDY_IMM: y = lo;
				cpu_pkg::OP_ADC_IMM: begin
					sum = {1'b0, a} + {1'b0, lo} + {8'd0, c};
					a   = sum[7:0];
					c   = sum[8];
				end
				cpu_pkg::OP_AND_IMM: a = a & lo;
				cpu_pkg::OP_ORA_IMM: a = a | lo;
				cpu_pkg::OP_EOR_IMM: a = a ^ lo;
				cpu_pkg::OP_TAX: x = a;
				cpu_pkg::OP_TAY: y = a;
				cpu_pkg::OP_INX: x = x + 8'd1;
				cpu_pkg::OP_INY: y = y + 8'd1;
				cpu_pkg::OP_CLC: c = 1'b0;
				cpu_pkg::OP_SEC: c = 1'b1;
				cpu_pkg::OP_STA_ABS: exp_stores.push_back({target, a});
				cpu_pkg::OP_STX_ABS: exp_stores.push_back({target, x});
				cpu_pkg::OP_JMP_ABS: begin
					jump_targets.push_back(target);
					halted = (target == HALT_ADDR);
				end
				default: ;
			endcase
			case (op)
				cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_LDY_IMM,
				cpu_pkg::OP_ADC_IMM, cpu_pkg::OP_AND_IMM, cpu_pkg::OP_ORA_IMM,
				cpu_pkg::OP_EOR_IMM:
					pc = pc + 16'd2;
				cpu_pkg::OP_STA_ABS, cpu_pkg::OP_STX_ABS:
					pc = pc + 16'd3;
				cpu_pkg::OP_JMP_ABS:
					pc = target;
				default:
					pc = pc + 16'd1;
			endcase
		end
		assert (halted) else stop_on_failure("reference model never reached the halt jump");
	endtask

	////////////////////
	// Result checks

	task automatic check_stores();
		logic [23:0] got;
		logic [23:0] want;
		// Skipped block first, on every store the memory saw
		for (int i = 0; i < i_mem.store_log.size(); i++) begin
			assert (i_mem.store_log[i][23:8] != SKIP_ADDR) else
				stop_on_failure("a store reached the address inside the skipped block");
		end
		assert (i_mem.store_log.size() == exp_stores.size()) else
			stop_on_failure($sformatf("error: store count got %h expected %h",
				i_mem.store_log.size(), exp_stores.size()));
		for (int i = 0; i < exp_stores.size(); i++) begin
			got  = i_mem.store_log[i];
			want = exp_stores[i];
			assert (got == want) else
				stop_on_failure($sformatf(
					"error: store %0d wb_adr=%h wb_dat_w=%h expected wb_adr=%h wb_dat_w=%h",
					i, got[23:8], got[7:0], want[23:8], want[7:0]));
		end
	endtask

	// Reads run in sequence except where a jump sends them to its target
	task automatic check_fetch_order();
		int          t;
		logic        have_prev;
		logic [15:0] prev;
		logic [15:0] adr;
		t         = 0;
		have_prev = 1'b0;
		prev      = '0;
		assert (xfer_log.size() > 0 && xfer_log[0] == {1'b0, RESET_VECTOR}) else
			stop_on_failure("first bus transfer after reset was not a read at the reset vector");
		foreach (xfer_log[i]) begin
			if (!xfer_log[i][16]) begin
				adr = xfer_log[i][15:0];
				if (have_prev && adr != prev + 16'd1) begin
					assert (t < jump_targets.size()) else
						stop_on_failure("fetch address jumped with no jump left to explain it");
					assert (adr == jump_targets[t]) else
						stop_on_failure($sformatf("error: wb_adr after jump got %h expected %h",
							adr, jump_targets[t]));
					t++;
				end
				prev      = adr;
				have_prev = 1'b1;
			end
		end
		assert (t == jump_targets.size()) else
			stop_on_failure("not every jump target was fetched");
	endtask

	////////////////////
	// Bus rules

	assert property (@(posedge phi2_int) !rst_n |=> !wb_cyc && !wb_stb && !sync)
		else stop_on_failure("bus cycle or sync active during or right after reset");

	assert property (@(posedge phi2_int) disable iff (!rst_n) wb_cyc == wb_stb)
		else stop_on_failure("wb_cyc and wb_stb differ");

	assert property (@(posedge phi2_int) disable iff (!rst_n)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
		else stop_on_failure("bus request changed while waiting for ack");

	assert property (@(posedge phi2_int) disable iff (!rst_n) wb_stb && wb_ack |=> !wb_stb)
		else stop_on_failure("wb_stb stayed high in the cycle after ack");

	// Mid cycle sampling of sync and transfer starts
	always @(negedge phi2_int) begin
		if (rst_n === 1'b1) begin
			if (sync === 1'b1) begin
				sync_count++;
			end
			if (wb_stb === 1'b1 && !stb_seen) begin
				xfer_log.push_back({wb_we, wb_adr});
			end
		end
		stb_seen = (wb_stb === 1'b1);
	end

	initial begin
		phi2_int = 1'b0;
		forever begin
			#(CLK_PERIOD / 2);
			phi2_int = ~phi2_int;
		end
	end

	initial begin
		time limit;
		wait (prog_len > 0);
		limit = prog_len * CYCLES_PER_BYTE * CLK_PERIOD + 2000;
		#(limit);
		stop_on_failure("timeout: the stores did not complete and the core never halted");
	end

	initial begin
		rst_n = 1'b0;
		build_program();
		run_model();
		prog_len = prog.size();
		@(posedge phi2_int);
		foreach (prog[i]) begin
			i_mem.write_byte(RESET_VECTOR + 16'(i), prog[i]);
		end
		repeat (3) @(posedge phi2_int);
		#(DRIVE_DELAY);
		rst_n = 1'b1;
		// Parked on the read of the halt address
		while (!(wb_stb === 1'b1 && wb_we === 1'b0 && wb_adr === HALT_ADDR)) begin
			@(negedge phi2_int);
		end
		// One more sample so the transfer log holds the halt read
		@(negedge phi2_int);
		check_stores();
		check_fetch_order();
		assert (sync_count == model_instr) else
			stop_on_failure($sformatf("error: sync pulses got %h expected %h",
				sync_count, model_instr));
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/tb_memory.sv
// Wishbone slave memory model
// 64 KB byte array, 0 to 3 random wait states, logs every acked store.
// A read at the halt address is never acked, which parks the core
`timescale 1ns/1ps
`default_nettype none

module tb_memory #(
	parameter logic [31:0] SEED = 32'h1,
	parameter logic [cpu_pkg::ADDR_WIDTH-1:0] HALT_ADDR = 16'hFFF0
) (
	input  wire                                 phi2_int,
	input  wire                                 wb_cyc,
	input  wire                                 wb_stb,
	input  wire                                 wb_we,
	input  wire [cpu_pkg::ADDR_WIDTH-1:0]       wb_adr,
	input  wire [cpu_pkg::DATA_WIDTH-1:0]       wb_dat_w,
	output logic [cpu_pkg::DATA_WIDTH-1:0]      wb_dat_r,
	output logic                                wb_ack
);

	logic [cpu_pkg::DATA_WIDTH-1:0] mem [65536];
	// Address in the upper 16 bits, data in the lower 8
	logic [23:0]                    store_log [$];

	task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
		mem[addr] = data;
	endtask

	initial begin
		int unsigned wait_left;
		logic        busy;
		logic [15:0] adr;
		logic        we;
		logic [7:0]  dat;
		void'($urandom(SEED));
		for (int i = 0; i < 65536; i++) begin
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
		end
		wb_ack    = 1'b0;
		wb_dat_r  = '0;
		busy      = 1'b0;
		wait_left = 0;
		forever begin
			@(posedge phi2_int);
			#2;
			if (wb_ack) begin
				// Master sampled ack on this edge
				if (we) begin
					mem[adr] = dat;
					store_log.push_back({adr, dat});
				end
				wb_ack = 1'b0;
				busy   = 1'b0;
			end else if (!busy && wb_cyc && wb_stb) begin
				busy      = 1'b1;
				adr       = wb_adr;
				we        = wb_we;
				dat       = wb_dat_w;
				wait_left = $urandom_range(3, 0);
			end
			if (busy && !wb_ack) begin
				if (wait_left != 0) begin
					wait_left--;
				end else if (we || adr != HALT_ADDR) begin
					wb_dat_r = we ? 8'h00 : mem[adr];
					wb_ack   = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/cpu_top.sv
// CPU top level
// Small 6502 style core: fetch, prefetch queue, execute and a shared
// Wishbone classic master port
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter int QUEUE_DEPTH = 4,
	parameter logic [cpu_pkg::ADDR_WIDTH-1:0] RESET_VECTOR = 16'h0200
) (
	input  wire                                 phi2_int,
	input  wire                                 rst_n,
	input  wire [cpu_pkg::DATA_WIDTH-1:0]       wb_dat_r,
	input  wire                                 wb_ack,
	output wire                                 wb_cyc,
	output wire                                 wb_stb,
	output wire                                 wb_we,
	output wire [cpu_pkg::ADDR_WIDTH-1:0]       wb_adr,
	output wire [cpu_pkg::DATA_WIDTH-1:0]       wb_dat_w,
	output wire                                 sync
);

	wire cpu_pkg::bus_req_t           fetch_req;
	wire cpu_pkg::bus_req_t           store_req;
	wire                              fetch_valid;
	wire                              fetch_done;
	wire [cpu_pkg::DATA_WIDTH-1:0]    fetch_data;
	wire                              store_valid;
	wire                              store_done;
	wire                              push;
	wire [cpu_pkg::DATA_WIDTH-1:0]    push_data;
	wire                              pop;
	wire                              empty;
	wire                              full;
	wire [$clog2(QUEUE_DEPTH):0]      count;
	wire [cpu_pkg::DATA_WIDTH-1:0]    head_data;
	wire                              redirect;
	wire [cpu_pkg::ADDR_WIDTH-1:0]    redirect_addr;

	fetch_unit #(
		.RESET_VECTOR (RESET_VECTOR),
		.QUEUE_DEPTH  (QUEUE_DEPTH)
	) i_fetch (
		.phi2_int      (phi2_int),
		.rst_n         (rst_n),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.full          (full),
		.count         (count),
		.fetch_done    (fetch_done),
		.fetch_data    (fetch_data),
		.fetch_req     (fetch_req),
		.fetch_valid   (fetch_valid),
		.push          (push),
		.push_data     (push_data)
	);

	prefetch_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) i_queue (
		.phi2_int  (phi2_int),
		.rst_n     (rst_n),
		.clear     (redirect),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.head_data (head_data),
		.empty     (empty),
		.full      (full),
		.count     (count)
	);

	execute_unit i_exec (
		.phi2_int      (phi2_int),
		.rst_n         (rst_n),
		.empty         (empty),
		.head_data     (head_data),
		.store_done    (store_done),
		.pop           (pop),
		.sync          (sync),
		.store_req     (store_req),
		.store_valid   (store_valid),
		.redirect      (redirect),
		.redirect_addr (redirect_addr)
	);

	bus_master i_bus (
		.phi2_int    (phi2_int),
		.rst_n       (rst_n),
		.fetch_req   (fetch_req),
		.fetch_valid (fetch_valid),
		.store_req   (store_req),
		.store_valid (store_valid),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.fetch_done  (fetch_done),
		.fetch_data  (fetch_data),
		.store_done  (store_done),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w)
	);

endmodule

`default_nettype wire

//--- source/bus_master.sv
// Bus master
// Wishbone classic master shared by stores and instruction fetches;
// a waiting store is started before a waiting fetch
`timescale 1ns/1ps
`default_nettype none

module bus_master (
	input  wire                                 phi2_int,
	input  wire                                 rst_n,
	input  cpu_pkg::bus_req_t                   fetch_req,
	input  wire                                 fetch_valid,
	input  cpu_pkg::bus_req_t                   store_req,
	input  wire                                 store_valid,
	input  wire [cpu_pkg::DATA_WIDTH-1:0]       wb_dat_r,
	input  wire                                 wb_ack,
	output logic                                fetch_done,
	output logic [cpu_pkg::DATA_WIDTH-1:0]      fetch_data,
	output logic                                store_done,
	output logic                                wb_cyc,
	output logic                                wb_stb,
	output logic                                wb_we,
	output logic [cpu_pkg::ADDR_WIDTH-1:0]      wb_adr,
	output logic [cpu_pkg::DATA_WIDTH-1:0]      wb_dat_w
);

	typedef enum logic {BUS_IDLE, BUS_BUSY} bus_state_e;

	bus_state_e        state;
	cpu_pkg::bus_req_t req;
	logic              owner_store;

	// Request held stable until ack
	assign wb_cyc   = (state == BUS_BUSY);
	assign wb_stb   = (state == BUS_BUSY);
	assign wb_we    = req.we;
	assign wb_adr   = req.addr;
	assign wb_dat_w = req.wdata;

	// Done pulses on the ack cycle
	assign fetch_done = wb_stb && wb_ack && !owner_store;
	assign store_done = wb_stb && wb_ack && owner_store;
	assign fetch_data = wb_dat_r;

	always_ff @(posedge phi2_int) begin
		if (!rst_n) begin
			state       <= BUS_IDLE;
			owner_store <= 1'b0;
		end else if (state == BUS_IDLE) begin
			if (store_valid) begin
				owner_store <= 1'b1;
				state       <= BUS_BUSY;
			end else if (fetch_valid) begin
				owner_store <= 1'b0;
				state       <= BUS_BUSY;
			end
		end else if (wb_ack) begin
			state <= BUS_IDLE;
		end
	end

	always_ff @(posedge phi2_int) begin
		if (state == BUS_IDLE) begin
			req <= store_valid ? store_req : fetch_req;
		end
	end

endmodule

`default_nettype wire

//--- source/execute_unit.sv
// Execute unit
// Decodes opcodes from the prefetch queue, gathers operands, runs the ALU
// on A, X, Y and carry, and issues stores and jumps
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  wire                                 phi2_int,
	input  wire                                 rst_n,
	input  wire                                 empty,
	input  wire [cpu_pkg::DATA_WIDTH-1:0]       head_data,
	input  wire                                 store_done,
	output logic                                pop,
	output logic                                sync,
	output cpu_pkg::bus_req_t                   store_req,
	output logic                                store_valid,
	output logic                                redirect,
	output logic [cpu_pkg::ADDR_WIDTH-1:0]      redirect_addr
);

	cpu_pkg::exec_state_e           state;
	cpu_pkg::opcode_e               opcode;
	cpu_pkg::opcode_e               head_op;
	logic [cpu_pkg::DATA_WIDTH-1:0] a;
	logic [cpu_pkg::DATA_WIDTH-1:0] x;
	logic [cpu_pkg::DATA_WIDTH-1:0] y;
	logic                           carry;
	logic [cpu_pkg::DATA_WIDTH-1:0] operand_lo;
	logic [cpu_pkg::ADDR_WIDTH-1:0] store_addr;
	logic [cpu_pkg::DATA_WIDTH-1:0] store_data;
	logic [cpu_pkg::DATA_WIDTH:0]   adc_sum;

	// Operand bytes following each opcode
	function automatic logic [1:0] operand_bytes(input cpu_pkg::opcode_e op);
		case (op)
			cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_LDY_IMM,
			cpu_pkg::OP_ADC_IMM, cpu_pkg::OP_AND_IMM, cpu_pkg::OP_ORA_IMM,
			cpu_pkg::OP_EOR_IMM:
				operand_bytes = 2'd1;
			cpu_pkg::OP_STA_ABS, cpu_pkg::OP_STX_ABS, cpu_pkg::OP_JMP_ABS:
				operand_bytes = 2'd2;
			default:
				operand_bytes = 2'd0;
		endcase
	endfunction

	assign head_op = cpu_pkg::opcode_e'(head_data);
	assign adc_sum = {1'b0, a} + {1'b0, head_data} + {{cpu_pkg::DATA_WIDTH{1'b0}}, carry};

	assign pop  = !empty && (state != cpu_pkg::EX_STORE_WAIT);
	assign sync = !empty && (state == cpu_pkg::EX_OPCODE);

	// Jump leaves on the high operand byte
	assign redirect      = !empty && (state == cpu_pkg::EX_OPERAND_HI) &&
	                       (opcode == cpu_pkg::OP_JMP_ABS);
	assign redirect_addr = {head_data, operand_lo};

	assign store_req = '{addr: store_addr, wdata: store_data, we: 1'b1};

	////////////////////
	// FSM and registers

	always_ff @(posedge phi2_int) begin
		if (!rst_n) begin
			state       <= cpu_pkg::EX_OPCODE;
			a           <= '0;
			x           <= '0;
			y           <= '0;
			carry       <= 1'b0;
			store_valid <= 1'b0;
		end else begin
			case (state)
				cpu_pkg::EX_OPCODE: if (!empty) begin
					if (operand_bytes(head_op) != 2'd0) begin
						state <= cpu_pkg::EX_OPERAND_LO;
					end
					// Implied ops finish here, unknown ones act as NOP
					case (head_op)
						cpu_pkg::OP_TAX: x     <= a;
						cpu_pkg::OP_TAY: y     <= a;
						cpu_pkg::OP_INX: x     <= x + 1'b1;
						cpu_pkg::OP_INY: y     <= y + 1'b1;
						cpu_pkg::OP_CLC: carry <= 1'b0;
						cpu_pkg::OP_SEC: carry <= 1'b1;
						default: ;
					endcase
				end
				cpu_pkg::EX_OPERAND_LO: if (!empty) begin
					if (operand_bytes(opcode) == 2'd1) begin
						state <= cpu_pkg::EX_OPCODE;
						case (opcode)
							cpu_pkg::OP_LDA_IMM: a <= head_data;
							cpu_pkg::OP_LDX_IMM: x <= head_data;
							cpu_pkg::OP_LDY_IMM: y <= head_data;
							cpu_pkg::OP_ADC_IMM: {carry, a} <= adc_sum;
							cpu_pkg::OP_AND_IMM: a <= a & head_data;
							cpu_pkg::OP_ORA_IMM: a <= a | head_data;
							cpu_pkg::OP_EOR_IMM: a <= a ^ head_data;
							default: ;
						endcase
					end else begin
						state <= cpu_pkg::EX_OPERAND_HI;
					end
				end
				cpu_pkg::EX_OPERAND_HI: if (!empty) begin
					if (opcode == cpu_pkg::OP_JMP_ABS) begin
						state <= cpu_pkg::EX_OPCODE;
					end else begin
						store_valid <= 1'b1;
						state       <= cpu_pkg::EX_STORE_WAIT;
					end
				end
				cpu_pkg::EX_STORE_WAIT: if (store_done) begin
					store_valid <= 1'b0;
					state       <= cpu_pkg::EX_OPCODE;
				end
				default: state <= cpu_pkg::EX_OPCODE;
			endcase
		end
	end

	// Decoded opcode, operand and store payload
	always_ff @(posedge phi2_int) begin
		if (pop && state == cpu_pkg::EX_OPCODE) begin
			opcode <= head_op;
		end
		if (pop && state == cpu_pkg::EX_OPERAND_LO) begin
			operand_lo <= head_data;
		end
		if (pop && state == cpu_pkg::EX_OPERAND_HI) begin
			store_addr <= {head_data, operand_lo};
			store_data <= (opcode == cpu_pkg::OP_STX_ABS) ? x : a;
		end
	end

endmodule

`default_nettype wire

//--- source/prefetch_queue.sv
// Prefetch queue
// Circular buffer of fetched instruction bytes; flushed on a jump
`timescale 1ns/1ps
`default_nettype none

module prefetch_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire                                 phi2_int,
	input  wire                                 rst_n,
	input  wire                                 clear,
	input  wire                                 push,
	input  wire [cpu_pkg::DATA_WIDTH-1:0]       push_data,
	input  wire                                 pop,
	output logic [cpu_pkg::DATA_WIDTH-1:0]      head_data,
	output logic                                empty,
	output logic                                full,
	output logic [$clog2(QUEUE_DEPTH):0]        count
);

	localparam int PW = $clog2(QUEUE_DEPTH);

	logic [cpu_pkg::DATA_WIDTH-1:0] mem [QUEUE_DEPTH];
	logic [PW-1:0]                  rd_ptr;
	logic [PW-1:0]                  wr_ptr;
	logic                           do_push;
	logic                           do_pop;

	assign empty     = (count == '0);
	assign full      = (count == (PW+1)'(QUEUE_DEPTH));
	assign head_data = mem[rd_ptr];

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	////////////////////
	// Pointers and count

	always_ff @(posedge phi2_int) begin
		if (!rst_n || clear) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	////////////////////
	// Storage

	always_ff @(posedge phi2_int) begin
		if (do_push && !clear) begin
			mem[wr_ptr] <= push_data;
		end
	end

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
// Fetch unit
// Reads instruction bytes ahead of execution, one read at a time, and
// pushes them into the prefetch queue; restarts at a jump target
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter logic [cpu_pkg::ADDR_WIDTH-1:0] RESET_VECTOR = 16'h0200,
	parameter int QUEUE_DEPTH = 4
) (
	input  wire                                 phi2_int,
	input  wire                                 rst_n,
	input  wire                                 redirect,
	input  wire [cpu_pkg::ADDR_WIDTH-1:0]       redirect_addr,
	input  wire                                 full,
	input  wire [$clog2(QUEUE_DEPTH):0]         count,
	input  wire                                 fetch_done,
	input  wire [cpu_pkg::DATA_WIDTH-1:0]       fetch_data,
	output cpu_pkg::bus_req_t                   fetch_req,
	output logic                                fetch_valid,
	output logic                                push,
	output logic [cpu_pkg::DATA_WIDTH-1:0]      push_data
);

	localparam int CW = $clog2(QUEUE_DEPTH) + 1;

	logic [cpu_pkg::ADDR_WIDTH-1:0] fetch_addr;
	logic                           stale;
	logic [CW:0]                    occupied;
	logic                           room;

	// Queue entries plus the byte still on the bus
	assign occupied = {1'b0, count} + (CW+1)'(fetch_valid);
	assign room     = !full && (occupied < (CW+1)'(QUEUE_DEPTH));

	// Bytes from before a jump are thrown away
	assign push      = fetch_done && !stale && !redirect;
	assign push_data = fetch_data;

	assign fetch_req = '{addr: fetch_addr, wdata: '0, we: 1'b0};

	always_ff @(posedge phi2_int) begin
		if (!rst_n) begin
			fetch_addr  <= RESET_VECTOR;
			fetch_valid <= 1'b0;
			stale       <= 1'b0;
		end else begin
			if (redirect) begin
				fetch_addr <= redirect_addr;
			end else if (push) begin
				fetch_addr <= fetch_addr + 1'b1;
			end

			// A read still outstanding at a jump returns a stale byte
			if (redirect) begin
				stale <= fetch_valid && !fetch_done;
			end else if (fetch_done) begin
				stale <= 1'b0;
			end

			if (fetch_done) begin
				fetch_valid <= 1'b0;
			end else if (!fetch_valid && room) begin
				fetch_valid <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/cpu_pkg.sv
// CPU package
// Bus widths, 6502 opcode encodings, execute states and the bus request
// record shared by the fetch, execute and bus units
`default_nettype none

package cpu_pkg;

	// Fixed by the instruction set
	localparam int ADDR_WIDTH = 16;
	localparam int DATA_WIDTH = 8;

	// Kept opcodes, real 6502 encodings
	typedef enum logic [7:0] {
		OP_LDA_IMM = 8'hA9,
		OP_LDX_IMM = 8'hA2,
		OP_LDY_IMM = 8'hA0,
		OP_ADC_IMM = 8'h69,
		OP_AND_IMM = 8'h29,
		OP_ORA_IMM = 8'h09,
		OP_EOR_IMM = 8'h49,
		OP_TAX     = 8'hAA,
		OP_TAY     = 8'hA8,
		OP_INX     = 8'hE8,
		OP_INY     = 8'hC8,
		OP_CLC     = 8'h18,
		OP_SEC     = 8'h38,
		OP_STA_ABS = 8'h8D,
		OP_STX_ABS = 8'h8E,
		OP_JMP_ABS = 8'h4C,
		OP_NOP     = 8'hEA
	} opcode_e;

	typedef enum logic [1:0] {
		EX_OPCODE,
		EX_OPERAND_LO,
		EX_OPERAND_HI,
		EX_STORE_WAIT
	} exec_state_e;

	// One bus request, 25 bits
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] wdata;
		logic                  we;
	} bus_req_t;

endpackage

`default_nettype wire
